// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat nlc.f)) common/nlc_settings.svh

.PHONY: run clean

run: obj_dir/Vnlc_tb
	@out="$$(./obj_dir/Vnlc_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

obj_dir/Vnlc_tb: nlc.f $(SRCS)
	verilator --binary -Wno-fatal --top-module nlc_tb -f nlc.f

clean:
	rm -rf obj_dir

// File: nlc.f
+incdir+common
common/nlc_pkg.sv
common/mac_if.sv
hw/mac/mac_unit.sv
hw/param_bank.sv
hw/sample_codec.sv
hw/work_file.sv
hw/nlc_sequencer.sv
hw/nlc_top.sv
sim/nlc_tb.sv

// File: sim/nlc_vectors.txt
# C ch idx data: write one parameter, A idx data: write it on every channel
# S: one frame of input samples, E: the expected output frame, all in hex
# Identity polynomial
A 1 00100000
A 7 00100000
S 0c0000 140000 000000 1fffff
E 0c0000 140000 000000 1fffff
# Mean and scale on channels 0 and 1 only
C 0 6 fffc0000
C 0 7 00200000
C 1 6 00020000
C 1 7 00080000
S 060000 150000 060000 150000
E 040000 118000 060000 150000
# Fifth-order polynomial, c1 stays at 1.0
A 5 00080000
A 4 fffc0000
A 3 00020000
A 2 fff80000
A 0 00010000
S 000000 000003 080000 100001
E 19c000 01f81d 074000 00ffff
# Large c0 pushes every channel past full scale
A 0 00300000
C 1 0 ffe00000
C 3 0 fff00000
S 000000 000003 080000 100001
E 0fffff 1fffff 0fffff 1fffff
# Same frame again, straight after
S 000000 000003 080000 100001
E 0fffff 1fffff 0fffff 1fffff

// File: sim/nlc_tb.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module nlc_tb;
	import nlc_pkg::*;

	// Cycles any single handshake may take
	localparam int TIMEOUT = 400;

	logic clk;
	logic rst;
	logic cfg_valid;
	logic cfg_ready;
	chan_t cfg_channel;
	pidx_t cfg_index;
	fix_t cfg_data;
	logic in_valid;
	logic in_ready;
	logic [`NLC_SAMPLE_W-1:0] in_sample;
	logic out_valid;
	logic out_ready;
	logic [`NLC_SAMPLE_W-1:0] out_sample;

	integer seed;
	int fd;
	int code;
	int frames;
	logic [7:0] tag;
	logic [8*200-1:0] rest;
	logic [31:0] v_ch;
	logic [31:0] v_idx;
	logic [31:0] v_data;
	sample_t got;
	sample_t expected;

	nlc_top dut (
		.clk(clk),
		.rst(rst),
		.cfg_valid(cfg_valid),
		.cfg_ready(cfg_ready),
		.cfg_channel(cfg_channel),
		.cfg_index(cfg_index),
		.cfg_data(cfg_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_sample(in_sample),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_sample(out_sample)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
		abort_run();
	endtask

	task automatic reject_record(input string kind);
		$display("Malformed %s record in sim/nlc_vectors.txt", kind);
		abort_run();
	endtask

	task automatic check_sample(input sample_t actual, input sample_t want, input int pos);
		if (actual.raw !== want.raw) begin
			$display("[FAIL] %0t: frame %0d channel %0d gave sign %b mag %h, expected sign %b mag %h",
				$time, frames, pos, actual.f.sign, actual.f.mag, want.f.sign, want.f.mag);
			abort_run();
		end
	endtask

	task automatic check_ready(input logic actual, input logic want, input string what);
		if (actual !== want) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, actual, want);
			abort_run();
		end
	endtask

	// All handshake tasks start and end 1 ns after a rising edge
	task automatic write_config(input chan_t ch, input pidx_t idx, input fix_t data);
		int cycles;
		cycles = 0;
		cfg_valid = 1'b1;
		cfg_channel = ch;
		cfg_index = idx;
		cfg_data = data;
		@(negedge clk);
		while (!cfg_ready) begin
			cycles++;
			if (cycles > TIMEOUT) report_timeout("cfg_ready on a configuration write");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cfg_valid = 1'b0;
	endtask

	task automatic send_sample(input logic [`NLC_SAMPLE_W-1:0] s);
		int cycles;
		cycles = 0;
		in_valid = 1'b1;
		in_sample = s;
		@(negedge clk);
		while (!in_ready) begin
			cycles++;
			if (cycles > TIMEOUT) report_timeout("in_ready on an input sample");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		// Parameters are locked once a frame has started
		check_ready(cfg_ready, 1'b0, "cfg_ready after an accepted sample");
	endtask

	task automatic receive_sample(output sample_t s);
		int cycles;
		logic done;
		logic [31:0] rnd;
		cycles = 0;
		done = 1'b0;
		while (!done) begin
			rnd = $random(seed);
			out_ready = (rnd[1:0] != 2'b00);
			@(negedge clk);
			check_ready(in_ready, 1'b0, "in_ready while a frame is in flight");
			check_ready(cfg_ready, 1'b0, "cfg_ready while a frame is in flight");
			if (out_valid && out_ready) begin
				s.raw = out_sample;
				done = 1'b1;
			end
			@(posedge clk);
			#1;
			cycles++;
			if (!done && cycles > TIMEOUT) report_timeout("an output transfer");
		end
		out_ready = 1'b0;
	endtask

	initial begin
		seed = 32'h9af7_cba9;
		rst = 1'b1;
		cfg_valid = 1'b0;
		cfg_channel = '0;
		cfg_index = '0;
		cfg_data = '0;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b0;
		frames = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check_ready(cfg_ready, 1'b1, "cfg_ready after reset");
		check_ready(in_ready, 1'b1, "in_ready after reset");
		check_ready(out_valid, 1'b0, "out_valid after reset");

		fd = $fopen("sim/nlc_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/nlc_vectors.txt");
			abort_run();
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			case (tag)
				"#": code = $fgets(rest, fd);
				"C": begin
					code = $fscanf(fd, "%h %h %h", v_ch, v_idx, v_data);
					if (code != 3) reject_record("C");
					write_config(chan_t'(v_ch), pidx_t'(v_idx), v_data);
				end
				"A": begin
					code = $fscanf(fd, "%h %h", v_idx, v_data);
					if (code != 2) reject_record("A");
					for (int i = 0; i < `NLC_CHANNELS; i++) begin
						write_config(chan_t'(i), pidx_t'(v_idx), v_data);
					end
				end
				"S": begin
					check_ready(in_ready, 1'b1, "in_ready before a frame");
					check_ready(cfg_ready, 1'b1, "cfg_ready before a frame");
					check_ready(out_valid, 1'b0, "out_valid before a frame");
					for (int i = 0; i < `NLC_CHANNELS; i++) begin
						code = $fscanf(fd, "%h", v_data);
						if (code != 1) reject_record("S");
						send_sample(v_data[`NLC_SAMPLE_W-1:0]);
					end
				end
				"E": begin
					for (int i = 0; i < `NLC_CHANNELS; i++) begin
						code = $fscanf(fd, "%h", v_data);
						if (code != 1) reject_record("E");
						expected.raw = v_data[`NLC_SAMPLE_W-1:0];
						receive_sample(got);
						check_sample(got, expected, i);
					end
					frames++;
				end
				default: reject_record("unknown");
			endcase
		end
		$fclose(fd);
		check_ready(in_ready, 1'b1, "in_ready after the last frame");
		if (frames == 0) begin
			$display("No frames found in sim/nlc_vectors.txt");
			abort_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

// File: hw/nlc_top.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module nlc_top (
	input logic clk,
	input logic rst,

	input logic cfg_valid,
	output logic cfg_ready,
	input nlc_pkg::chan_t cfg_channel,
	input nlc_pkg::pidx_t cfg_index,
	input nlc_pkg::fix_t cfg_data,

	input logic in_valid,
	output logic in_ready,
	input logic [`NLC_SAMPLE_W-1:0] in_sample,

	output logic out_valid,
	input logic out_ready,
	output logic [`NLC_SAMPLE_W-1:0] out_sample
);
	import nlc_pkg::*;

	sample_t in_s;
	sample_t out_s;
	logic busy;
	chan_t rd_ch;
	pidx_t rd_idx;
	fix_t rd_data;
	logic ld_valid;
	chan_t ld_ch;
	fix_t ld_fix;
	chan_t wf_ch;
	fix_t wf_norm;
	fix_t wf_acc;

	mac_if mi ();

	assign in_s.raw = in_sample;
	assign out_sample = out_s.raw;

	nlc_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_sample(in_s),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.busy(busy),
		.rd_ch(rd_ch),
		.rd_idx(rd_idx),
		.rd_data(rd_data),
		.ld_valid(ld_valid),
		.ld_ch(ld_ch),
		.ld_fix(ld_fix),
		.wf_ch(wf_ch),
		.wf_norm(wf_norm),
		.wf_acc(wf_acc),
		.mi(mi.issue),
		.mr(mi.writeback)
	);

	param_bank u_params (
		.clk(clk),
		.rst(rst),
		.busy(busy),
		.cfg_valid(cfg_valid),
		.cfg_ready(cfg_ready),
		.cfg_channel(cfg_channel),
		.cfg_index(cfg_index),
		.cfg_data(cfg_data),
		.rd_ch(rd_ch),
		.rd_idx(rd_idx),
		.rd_data(rd_data)
	);

	// Accumulator of the output channel goes straight to the codec
	sample_codec u_codec (
		.in_sample(in_s),
		.in_fix(ld_fix),
		.out_fix(wf_acc),
		.out_sample(out_s)
	);

	work_file u_work (
		.clk(clk),
		.rst(rst),
		.ld_valid(ld_valid),
		.ld_ch(ld_ch),
		.ld_fix(ld_fix),
		.mr(mi.writeback),
		.rd_ch(wf_ch),
		.rd_norm(wf_norm),
		.rd_acc(wf_acc)
	);

	mac_unit u_mac (
		.clk(clk),
		.rst(rst),
		.m(mi.unit)
	);

endmodule

// File: hw/nlc_sequencer.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module nlc_sequencer (
	input logic clk,
	input logic rst,

	input logic in_valid,
	output logic in_ready,
	input nlc_pkg::sample_t in_sample,

	output logic out_valid,
	input logic out_ready,

	output logic busy,

	output nlc_pkg::chan_t rd_ch,
	output nlc_pkg::pidx_t rd_idx,
	input nlc_pkg::fix_t rd_data,

	output logic ld_valid,
	output nlc_pkg::chan_t ld_ch,
	input nlc_pkg::fix_t ld_fix,

	output nlc_pkg::chan_t wf_ch,
	input nlc_pkg::fix_t wf_norm,
	input nlc_pkg::fix_t wf_acc,

	mac_if.issue mi,
	mac_if.writeback mr
);
	import nlc_pkg::*;

	localparam chan_t LAST_CH = chan_t'(`NLC_CHANNELS - 1);

	typedef enum logic [1:0] {
		S_LOAD,
		S_NORM,
		S_HORN,
		S_OUT
	} state_t;

	state_t state;
	chan_t ch;
	logic [2:0] pass;
	logic issuing;
	logic [2:0] inflight;
	logic drained;

	assign in_ready = (state == S_LOAD);
	assign ld_valid = in_valid && in_ready;
	assign ld_ch = ch;
	assign busy = !(state == S_LOAD && ch == '0);
	assign out_valid = (state == S_OUT);
	assign drained = !issuing && inflight == '0;

	assign rd_ch = ch;
	assign wf_ch = ch;

	always_comb begin
		rd_idx = '0;
		if (state == S_NORM) begin
			rd_idx = (pass == '0) ? PIDX_NEG_MEAN : PIDX_RECIP;
		end else if (state == S_HORN) begin
			rd_idx = pidx_t'(`NLC_ORDER - pass);
		end
	end

	// Operand selection for the current pass
	always_comb begin
		mi.req_valid = issuing;
		mi.req_ch = ch;
		mi.req_dest = (state == S_HORN) ? DEST_ACC : DEST_NORM;
		mi.a = wf_norm;
		mi.b = FIX_ONE;
		mi.c = rd_data;
		if (state == S_NORM && pass != '0) begin
			mi.b = rd_data;
			mi.c = '0;
		end else if (state == S_HORN) begin
			mi.a = (pass == '0) ? fix_t'(0) : wf_acc;
			mi.b = wf_norm;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inflight <= '0;
		end else begin
			inflight <= inflight + {2'b0, mi.req_valid} - {2'b0, mr.res_valid};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_LOAD;
			ch <= '0;
			pass <= '0;
			issuing <= 1'b0;
		end else begin
			case (state)
				S_LOAD: begin
					if (ld_valid) begin
						ch <= ch + 1'b1;
						if (ch == LAST_CH) begin
							ch <= '0;
							pass <= '0;
							issuing <= 1'b1;
							state <= S_NORM;
						end
					end
				end
				S_NORM, S_HORN: begin
					if (issuing) begin
						ch <= ch + 1'b1;
						if (ch == LAST_CH) begin
							ch <= '0;
							issuing <= 1'b0;
						end
					end else if (drained) begin
						issuing <= 1'b1;
						pass <= pass + 1'b1;
						if (state == S_NORM && pass != '0) begin
							pass <= '0;
							state <= S_HORN;
						end else if (state == S_HORN && pass == 3'(`NLC_ORDER)) begin
							pass <= '0;
							issuing <= 1'b0;
							state <= S_OUT;
						end
					end
				end
				S_OUT: begin
					if (out_ready) begin
						ch <= ch + 1'b1;
						if (ch == LAST_CH) begin
							ch <= '0;
							state <= S_LOAD;
						end
					end
				end
				default: state <= S_LOAD;
			endcase
		end
	end

endmodule

// File: hw/work_file.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module work_file (
	input logic clk,
	input logic rst,

	input logic ld_valid,
	input nlc_pkg::chan_t ld_ch,
	input nlc_pkg::fix_t ld_fix,

	mac_if.writeback mr,

	input nlc_pkg::chan_t rd_ch,
	output nlc_pkg::fix_t rd_norm,
	output nlc_pkg::fix_t rd_acc
);
	import nlc_pkg::*;

	fix_t norm_mem [`NLC_CHANNELS];
	fix_t acc_mem [`NLC_CHANNELS];

	assign rd_norm = norm_mem[rd_ch];
	assign rd_acc = acc_mem[rd_ch];

	// Loads and results never share a cycle
	always_ff @(posedge clk) begin
		if (!rst) begin
			if (ld_valid) begin
				norm_mem[ld_ch] <= ld_fix;
			end
			if (mr.res_valid && mr.res_dest == DEST_NORM) begin
				norm_mem[mr.res_ch] <= mr.res_value;
			end
			if (mr.res_valid && mr.res_dest == DEST_ACC) begin
				acc_mem[mr.res_ch] <= mr.res_value;
			end
		end
	end

endmodule

// File: hw/sample_codec.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module sample_codec (
	input nlc_pkg::sample_t in_sample,
	output nlc_pkg::fix_t in_fix,
	input nlc_pkg::fix_t out_fix,
	output nlc_pkg::sample_t out_sample
);
	import nlc_pkg::*;

	localparam int MAG_W = `NLC_SAMPLE_W - 1;

	fix_t in_mag;
	logic out_neg;
	logic signed [`NLC_FIX_W:0] out_abs;

	// Magnitude is taken as pure fraction bits
	assign in_mag = fix_t'({{(`NLC_FIX_W - MAG_W){1'b0}}, in_sample.f.mag});
	assign in_fix = in_sample.f.sign ? -in_mag : in_mag;

	// One extra bit so negating the most negative value cannot wrap
	assign out_neg = out_fix[`NLC_FIX_W-1];
	assign out_abs = out_neg ? -{out_fix[`NLC_FIX_W-1], out_fix}
		: {out_fix[`NLC_FIX_W-1], out_fix};

	always_comb begin
		out_sample.f.sign = out_neg;
		if (out_abs[`NLC_FIX_W:MAG_W] != '0) begin
			out_sample.f.mag = '1;
		end else begin
			out_sample.f.mag = out_abs[MAG_W-1:0];
		end
	end

endmodule

// File: hw/param_bank.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module param_bank (
	input logic clk,
	input logic rst,
	input logic busy,

	input logic cfg_valid,
	output logic cfg_ready,
	input nlc_pkg::chan_t cfg_channel,
	input nlc_pkg::pidx_t cfg_index,
	input nlc_pkg::fix_t cfg_data,

	input nlc_pkg::chan_t rd_ch,
	input nlc_pkg::pidx_t rd_idx,
	output nlc_pkg::fix_t rd_data
);
	import nlc_pkg::*;

	// c0..c5, neg_mean, recip_stdev per channel
	fix_t bank [`NLC_CHANNELS][8];

	assign cfg_ready = !busy;
	assign rd_data = bank[rd_ch][rd_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NLC_CHANNELS; i++) begin
				for (int j = 0; j < 8; j++) begin
					bank[i][j] <= '0;
				end
			end
		end else if (cfg_valid && cfg_ready) begin
			bank[cfg_channel][cfg_index] <= cfg_data;
		end
	end

endmodule

// File: hw/mac/mac_unit.sv
`timescale 1ns/1ps
`include "nlc_settings.svh"

module mac_unit (
	input logic clk,
	input logic rst,
	mac_if.unit m
);
	import nlc_pkg::*;

	logic s1_valid;
	chan_t s1_ch;
	dest_t s1_dest;
	logic signed [2*`NLC_FIX_W-1:0] s1_prod;
	fix_t s1_c;
	logic signed [2*`NLC_FIX_W-1:0] scaled;

	assign scaled = s1_prod >>> `NLC_FRAC;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			m.res_valid <= 1'b0;
		end else begin
			s1_valid <= m.req_valid;
			m.res_valid <= s1_valid;
		end
	end

	// Payload stages
	always_ff @(posedge clk) begin
		s1_prod <= m.a * m.b;
		s1_c <= m.c;
		s1_ch <= m.req_ch;
		s1_dest <= m.req_dest;
		m.res_value <= fix_t'(scaled[`NLC_FIX_W-1:0]) + s1_c;
		m.res_ch <= s1_ch;
		m.res_dest <= s1_dest;
	end

endmodule

// File: common/mac_if.sv
`timescale 1ns/1ps

interface mac_if;
	import nlc_pkg::*;

	logic req_valid;
	chan_t req_ch;
	dest_t req_dest;
	fix_t a;
	fix_t b;
	fix_t c;

	// Same tags, two cycles after the request
	logic res_valid;
	chan_t res_ch;
	dest_t res_dest;
	fix_t res_value;

	modport issue (
		output req_valid, req_ch, req_dest, a, b, c
	);

	modport unit (
		input req_valid, req_ch, req_dest, a, b, c,
		output res_valid, res_ch, res_dest, res_value
	);

	modport writeback (
		input res_valid, res_ch, res_dest, res_value
	);

endinterface

// File: common/nlc_pkg.sv
`include "nlc_settings.svh"

package nlc_pkg;

	// Sign-magnitude fields of one ADC sample
	typedef struct packed {
		logic sign;
		logic [`NLC_SAMPLE_W-2:0] mag;
	} sm_fields_t;

	typedef union packed {
		logic [`NLC_SAMPLE_W-1:0] raw;
		sm_fields_t f;
	} sample_t;

	typedef logic signed [`NLC_FIX_W-1:0] fix_t;

	typedef logic [$clog2(`NLC_CHANNELS)-1:0] chan_t;

	// 0..5 are c0..c5
	typedef logic [2:0] pidx_t;

	localparam pidx_t PIDX_NEG_MEAN = 3'd6;
	localparam pidx_t PIDX_RECIP = 3'd7;

	typedef enum logic {
		DEST_NORM = 1'b0,
		DEST_ACC = 1'b1
	} dest_t;

	localparam fix_t FIX_ONE = fix_t'(1) <<< `NLC_FRAC;

endpackage

// File: common/nlc_settings.svh
`ifndef NLC_SETTINGS_SVH
`define NLC_SETTINGS_SVH

// Channels per frame
`define NLC_CHANNELS 4

// Horner passes run from c5 down to c0
`define NLC_ORDER 5

`define NLC_SAMPLE_W 21
`define NLC_FIX_W 32

// 1.0 is 2**NLC_FRAC
`define NLC_FRAC 20

`endif
